// ==== bench/tb_io_subsys.sv ====
// Directed testbench for the IO subsystem.
// Drives the CPU and DMA AXI4-Lite ports and checks the free-run counter
// and the GPIO block against the register map, one task per test.

`timescale 1ns/10ps

`include "io_params.svh"

module tb_io_subsys
	import io_pkg::*;
();

	localparam int          TIMEOUT = 200;
	localparam int unsigned SEED    = 32'h1d13_e9b3;

	logic clk;
	logic rst_n;

	// Index 0 is the CPU port, index 1 the DMA port
	logic       [1:0]       awvalid;
	logic       [1:0]       awready;
	logic       [1:0][31:0] awaddr;
	logic       [1:0]       wvalid;
	logic       [1:0]       wready;
	io_data_t   [1:0]       wdata;
	logic       [1:0]       bvalid;
	logic       [1:0]       bready;
	axil_resp_t [1:0]       bresp;
	logic       [1:0]       arvalid;
	logic       [1:0]       arready;
	logic       [1:0][31:0] araddr;
	logic       [1:0]       rvalid;
	logic       [1:0]       rready;
	io_data_t   [1:0]       rdata;
	axil_resp_t [1:0]       rresp;

	logic       csr_mtie;
	logic       frc_cntr_val_leq;
	logic [7:0] gpio_in;
	logic [7:0] gpio_out;

	string cur_test;

	io_subsys_top uut (
		.clk, .rst_n,
		.cpu_awvalid(awvalid[0]), .cpu_awready(awready[0]), .cpu_awaddr(awaddr[0]),
		.cpu_wvalid(wvalid[0]), .cpu_wready(wready[0]), .cpu_wdata(wdata[0]),
		.cpu_bvalid(bvalid[0]), .cpu_bready(bready[0]), .cpu_bresp(bresp[0]),
		.cpu_arvalid(arvalid[0]), .cpu_arready(arready[0]), .cpu_araddr(araddr[0]),
		.cpu_rvalid(rvalid[0]), .cpu_rready(rready[0]), .cpu_rdata(rdata[0]),
		.cpu_rresp(rresp[0]),
		.dma_awvalid(awvalid[1]), .dma_awready(awready[1]), .dma_awaddr(awaddr[1]),
		.dma_wvalid(wvalid[1]), .dma_wready(wready[1]), .dma_wdata(wdata[1]),
		.dma_bvalid(bvalid[1]), .dma_bready(bready[1]), .dma_bresp(bresp[1]),
		.dma_arvalid(arvalid[1]), .dma_arready(arready[1]), .dma_araddr(araddr[1]),
		.dma_rvalid(rvalid[1]), .dma_rready(rready[1]), .dma_rdata(rdata[1]),
		.dma_rresp(rresp[1]),
		.csr_mtie, .frc_cntr_val_leq, .gpio_in, .gpio_out
	);

	always #10 clk = ~clk;

	task automatic stop_failed();
		$display("Finished with errors");
		$fatal(1, "stopping at the first failed check");
	endtask

	task automatic give_up(input string what);
		$display("Test %s: %s", cur_test, what);
		stop_failed();
	endtask

	task automatic require(input logic cond, input string what);
		if (!cond)
			give_up(what);
	endtask

	task automatic check_data(input io_data_t exp, input io_data_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", cur_test, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_resp(input axil_resp_t exp, input axil_resp_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected resp %b, actual resp %b", cur_test, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_bit(input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b, actual %b", cur_test, exp, act);
			stop_failed();
		end
	endtask

	function automatic logic [31:0] byte_addr(input io_adr_t adr);
		return {16'd0, adr, 2'b00};
	endfunction

	// Full-word write; bready is high from the start
	task automatic write_reg(input io_mst_t m, input io_adr_t adr, input io_data_t data);
		int         n;
		axil_resp_t resp;
		@(posedge clk);
		awvalid[m] <= 1'b1;
		wvalid[m]  <= 1'b1;
		awaddr[m]  <= byte_addr(adr);
		wdata[m]   <= data;
		bready[m]  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!(awready[m] && wready[m]) && n < TIMEOUT);
		require(awready[m] && wready[m], "write address and data were never accepted");
		@(posedge clk);
		awvalid[m] <= 1'b0;
		wvalid[m]  <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!bvalid[m] && n < TIMEOUT);
		require(bvalid[m], "write response never arrived");
		resp = bresp[m];
		@(posedge clk);
		bready[m] <= 1'b0;
		check_resp(AXIL_OKAY, resp);
	endtask

	// Read that keeps rready low for hold cycles after rvalid rises
	task automatic read_reg(input io_mst_t m, input io_adr_t adr, input int hold,
		output io_data_t data);
		int         n;
		axil_resp_t resp;
		@(posedge clk);
		arvalid[m] <= 1'b1;
		araddr[m]  <= byte_addr(adr);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!arready[m] && n < TIMEOUT);
		require(arready[m], "read address was never accepted");
		@(posedge clk);
		arvalid[m] <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rvalid[m] && n < TIMEOUT);
		require(rvalid[m], "read data never became valid");
		repeat (hold) begin
			@(negedge clk);
			require(rvalid[m], "rvalid dropped while rready was low");
		end
		data = rdata[m];
		resp = rresp[m];
		@(posedge clk);
		rready[m] <= 1'b1;
		@(posedge clk);
		rready[m] <= 1'b0;
		check_resp(AXIL_OKAY, resp);
	endtask

	task automatic register_readback();
		io_data_t lo;
		io_data_t hi;
		io_data_t pins;
		io_data_t got;
		cur_test = "register_readback";
		lo   = $urandom;
		hi   = $urandom;
		pins = $urandom;
		write_reg(MST_CPU, `IO_FRC_CMPLO, lo);
		write_reg(MST_CPU, `IO_FRC_CMPHI, hi);
		write_reg(MST_DMA, `IO_GPIO_OUT, pins);
		read_reg(MST_CPU, `IO_FRC_CMPLO, 0, got);
		check_data(lo, got);
		// High word keeps only the top byte of the 40-bit register
		read_reg(MST_DMA, `IO_FRC_CMPHI, 0, got);
		check_data({24'd0, hi[7:0]}, got);
		read_reg(MST_CPU, `IO_GPIO_OUT, 0, got);
		check_data({24'd0, pins[7:0]}, got);
		@(negedge clk);
		for (int i = 0; i < `IO_GPIO_WIDTH; i++)
			check_bit(pins[i], gpio_out[i]);
	endtask

	task automatic stopped_counter();
		io_data_t lo;
		io_data_t hi;
		io_data_t got;
		cur_test = "stopped_counter";
		lo = $urandom;
		hi = $urandom;
		write_reg(MST_CPU, `IO_FRC_CNTRL, 32'h0);
		write_reg(MST_CPU, `IO_FRC_VALLO, lo);
		write_reg(MST_CPU, `IO_FRC_VALHI, hi);
		repeat (20) @(posedge clk);
		read_reg(MST_CPU, `IO_FRC_VALLO, 0, got);
		check_data(lo, got);
		read_reg(MST_DMA, `IO_FRC_VALHI, 0, got);
		check_data({24'd0, hi[7:0]}, got);
		// Clear bit only, run stays off
		write_reg(MST_CPU, `IO_FRC_CNTRL, 32'h2);
		read_reg(MST_CPU, `IO_FRC_VALLO, 0, got);
		check_data(32'h0, got);
		read_reg(MST_CPU, `IO_FRC_VALHI, 0, got);
		check_data(32'h0, got);
	endtask

	task automatic running_counter();
		io_data_t first;
		io_data_t second;
		io_data_t third;
		cur_test = "running_counter";
		write_reg(MST_CPU, `IO_FRC_CNTRL, 32'h1);
		read_reg(MST_CPU, `IO_FRC_VALLO, 0, first);
		read_reg(MST_CPU, `IO_FRC_VALLO, 0, second);
		require(second > first, "counter did not advance between two reads");
		// Run and clear together restart the count from zero
		write_reg(MST_CPU, `IO_FRC_CNTRL, 32'h3);
		read_reg(MST_CPU, `IO_FRC_VALLO, 0, third);
		require(third < second, "counter was not cleared while running");
	endtask

	task automatic compare_output();
		cur_test = "compare_output";
		write_reg(MST_CPU, `IO_FRC_CMPLO, 32'hffff_ffff);
		write_reg(MST_CPU, `IO_FRC_CMPHI, 32'h0000_00ff);
		@(posedge clk);
		csr_mtie <= 1'b1;
		write_reg(MST_CPU, `IO_FRC_CNTRL, 32'h3);
		@(negedge clk);
		check_bit(1'b1, frc_cntr_val_leq);
		@(posedge clk);
		csr_mtie <= 1'b0;
		@(negedge clk);
		check_bit(1'b0, frc_cntr_val_leq);
		@(posedge clk);
		csr_mtie <= 1'b1;
		write_reg(MST_CPU, `IO_FRC_CMPLO, 32'h0);
		write_reg(MST_CPU, `IO_FRC_CMPHI, 32'h0);
		@(negedge clk);
		check_bit(1'b0, frc_cntr_val_leq);
	endtask

	task automatic both_masters();
		io_data_t a;
		io_data_t b;
		io_data_t got_cpu;
		io_data_t got_dma;
		cur_test = "both_masters";
		a = $urandom;
		b = $urandom;
		fork
			write_reg(MST_CPU, `IO_GPIO_OUT, a);
			write_reg(MST_DMA, `IO_FRC_CMPLO, b);
		join
		fork
			read_reg(MST_CPU, `IO_GPIO_OUT, 0, got_cpu);
			read_reg(MST_DMA, `IO_FRC_CMPLO, 6, got_dma);
		join
		check_data({24'd0, a[7:0]}, got_cpu);
		check_data(b, got_dma);
		// Nothing is mapped here, the chain returns zero
		fork
			read_reg(MST_CPU, 14'h0100, 0, got_cpu);
			read_reg(MST_DMA, 14'h3E10, 3, got_dma);
		join
		check_data(32'h0, got_cpu);
		check_data(32'h0, got_dma);
	endtask

	task automatic gpio_edges();
		io_data_t pins;
		io_data_t got;
		cur_test = "gpio_edges";
		pins = $urandom;
		if (pins[7:0] == 8'h00)
			pins = 32'h5a;
		write_reg(MST_CPU, `IO_GPIO_EDGE, 32'hff);
		@(posedge clk);
		gpio_in <= pins[7:0];
		repeat (5) @(posedge clk);
		read_reg(MST_CPU, `IO_GPIO_IN, 0, got);
		check_data({24'd0, pins[7:0]}, got);
		read_reg(MST_DMA, `IO_GPIO_EDGE, 0, got);
		check_data({24'd0, pins[7:0]}, got);
		write_reg(MST_DMA, `IO_GPIO_EDGE, 32'h0f);
		read_reg(MST_CPU, `IO_GPIO_EDGE, 0, got);
		check_data({24'd0, pins[7:0] & 8'hf0}, got);
		write_reg(MST_CPU, `IO_GPIO_EDGE, 32'hff);
		read_reg(MST_CPU, `IO_GPIO_EDGE, 0, got);
		check_data(32'h0, got);
	endtask

	initial begin
		int unsigned seed_ret;
		clk      = 1'b0;
		rst_n    = 1'b0;
		awvalid  = '0;
		awaddr   = '0;
		wvalid   = '0;
		wdata    = '0;
		bready   = '0;
		arvalid  = '0;
		araddr   = '0;
		rready   = '0;
		csr_mtie = 1'b0;
		gpio_in  = '0;
		seed_ret = $urandom(SEED);
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		cur_test = "reset";
		@(negedge clk);
		check_bit(1'b0, |{awready, wready, arready, bvalid, rvalid});
		check_bit(1'b0, frc_cntr_val_leq);
		check_data(32'h0, {24'd0, gpio_out});
		register_readback();
		stopped_counter();
		running_counter();
		compare_output();
		both_masters();
		gpio_edges();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== hw/axil_io_bridge.sv ====
// AXI4-Lite slave port to IO bus request converter.
// Accepts one transaction at a time, requests the IO bus until the
// arbiter grants it, then returns the write or read response.

`timescale 1ns/10ps

module axil_io_bridge
	import io_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	// AXI4-Lite write address and data
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  io_data_t    wdata,
	// Write response
	output logic        bvalid,
	input  logic        bready,
	output axil_resp_t  bresp,
	// Read address and data
	input  logic        arvalid,
	output logic        arready,
	input  logic [31:0] araddr,
	output logic        rvalid,
	input  logic        rready,
	output io_data_t    rdata,
	output axil_resp_t  rresp,
	// Toward the arbiter
	output logic        req,
	output logic        req_we,
	output io_adr_t     req_adr,
	output io_data_t    req_wdata,
	input  logic        gnt,
	input  io_data_t    gnt_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_RESP
	} state_t;

	state_t   state;
	logic     wr_accept;
	logic     rd_accept;
	logic     resp_done;
	io_data_t rdata_q;

	// Writes win when both channels present at once
	assign wr_accept = (state == ST_IDLE) && awvalid && wvalid;
	assign rd_accept = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

	assign awready = wr_accept;
	assign wready  = wr_accept;
	assign arready = rd_accept;

	assign req = (state == ST_REQ);

	assign bvalid = (state == ST_RESP) && req_we;
	assign rvalid = (state == ST_RESP) && !req_we;
	assign bresp  = AXIL_OKAY;
	assign rresp  = AXIL_OKAY;
	assign rdata  = rdata_q;

	assign resp_done = (bvalid && bready) || (rvalid && rready);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (wr_accept || rd_accept) state <= ST_REQ;
				ST_REQ:  if (gnt) state <= ST_RESP;
				ST_RESP: if (resp_done) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Latched transaction, byte address reduced to the word address
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			req_we    <= 1'b1;
			req_adr   <= awaddr[15:2];
			req_wdata <= wdata;
		end else if (rd_accept) begin
			req_we  <= 1'b0;
			req_adr <= araddr[15:2];
		end
		// Read data is only valid in the grant cycle
		if (req && gnt)
			rdata_q <= gnt_rdata;
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== hw/io_bus_arbiter.sv ====
// Round-robin arbiter between the CPU and DMA bridges.
// Grants one request per cycle, drives the IO bus from the winner and
// hands the read chain result back to the bridges.

`timescale 1ns/10ps

module io_bus_arbiter
	import io_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	// CPU bridge
	input  logic     cpu_req,
	input  logic     cpu_we,
	input  io_adr_t  cpu_adr,
	input  io_data_t cpu_wdata,
	output logic     cpu_gnt,
	// DMA bridge
	input  logic     dma_req,
	input  logic     dma_we,
	input  io_adr_t  dma_adr,
	input  io_data_t dma_wdata,
	output logic     dma_gnt,
	// Read data to whichever bridge holds the grant
	output io_data_t gnt_rdata,
	// IO bus
	output logic     io_we,
	output logic     io_radr_en,
	output io_adr_t  io_adr,
	output io_data_t io_wdata,
	input  io_data_t io_rdata
);

	io_mst_t last_gnt;

	// On a tie the master not served last wins
	assign cpu_gnt = cpu_req && (!dma_req || (last_gnt == MST_DMA));
	assign dma_gnt = dma_req && (!cpu_req || (last_gnt == MST_CPU));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			last_gnt <= MST_DMA;
		else if (cpu_gnt)
			last_gnt <= MST_CPU;
		else if (dma_gnt)
			last_gnt <= MST_DMA;
	end

	assign io_we      = (cpu_gnt && cpu_we) || (dma_gnt && dma_we);
	assign io_radr_en = (cpu_gnt && !cpu_we) || (dma_gnt && !dma_we);
	assign io_adr     = dma_gnt ? dma_adr : cpu_adr;
	assign io_wdata   = dma_gnt ? dma_wdata : cpu_wdata;

	// Only the granted bridge samples this
	assign gnt_rdata = io_rdata;

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_gnt && dma_gnt) && !(io_we && io_radr_en));

	// A losing master is served in the next cycle
	a_cpu_fair: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_req && !cpu_gnt |=> cpu_gnt);

	a_dma_fair: assert property (@(posedge clk) disable iff (!rst_n)
		dma_req && !dma_gnt |=> dma_gnt);

endmodule

// ==== hw/io_frc.sv ====
// Free-run counter slave on the IO bus, used as the machine timer.
// Counter and compare values are written as a low word and a high byte.
// The compare output goes to the core as the timer interrupt request.

`timescale 1ns/10ps

`include "io_params.svh"

module io_frc
	import io_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	// IO bus
	input  logic     io_we,
	input  logic     io_radr_en,
	input  io_adr_t  io_adr,
	input  io_data_t io_wdata,
	input  io_data_t io_rdata_in,
	output io_data_t io_rdata,
	// Core side
	input  logic     csr_mtie,
	output logic     frc_cntr_val_leq
);

	localparam int HI_W = `IO_FRC_WIDTH - 32;

	logic [`IO_FRC_WIDTH-1:0] cntr_val;
	logic [`IO_FRC_WIDTH-1:0] cmp_val;
	logic                     run;
	logic                     cntr_clr;

	logic we_vallo;
	logic we_valhi;
	logic we_cmplo;
	logic we_cmphi;
	logic we_cntrl;

	assign we_vallo = io_we && (io_adr == `IO_FRC_VALLO);
	assign we_valhi = io_we && (io_adr == `IO_FRC_VALHI);
	assign we_cmplo = io_we && (io_adr == `IO_FRC_CMPLO);
	assign we_cmphi = io_we && (io_adr == `IO_FRC_CMPHI);
	assign we_cntrl = io_we && (io_adr == `IO_FRC_CNTRL);

	// Clear bit acts once and is not stored
	assign cntr_clr = we_cntrl && io_wdata[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cntr_val <= '0;
		else if (cntr_clr)
			cntr_val <= '0;
		else if (we_vallo)
			cntr_val <= {cntr_val[`IO_FRC_WIDTH-1:32], io_wdata};
		else if (we_valhi)
			cntr_val <= {io_wdata[HI_W-1:0], cntr_val[31:0]};
		else if (run)
			cntr_val <= cntr_val + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cmp_val <= '0;
		else if (we_cmplo)
			cmp_val <= {cmp_val[`IO_FRC_WIDTH-1:32], io_wdata};
		else if (we_cmphi)
			cmp_val <= {io_wdata[HI_W-1:0], cmp_val[31:0]};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			run <= 1'b0;
		else if (we_cntrl)
			run <= io_wdata[0];
	end

	// Read chain, pass through unless one of our addresses is read
	always_comb begin
		io_rdata = io_rdata_in;
		if (io_radr_en) begin
			case (io_adr)
				`IO_FRC_VALLO: io_rdata = cntr_val[31:0];
				`IO_FRC_VALHI: io_rdata = 32'(cntr_val[`IO_FRC_WIDTH-1:32]);
				`IO_FRC_CMPLO: io_rdata = cmp_val[31:0];
				`IO_FRC_CMPHI: io_rdata = 32'(cmp_val[`IO_FRC_WIDTH-1:32]);
				`IO_FRC_CNTRL: io_rdata = {31'd0, run};
				default:       io_rdata = io_rdata_in;
			endcase
		end
	end

	assign frc_cntr_val_leq = (cntr_val <= cmp_val) && run && csr_mtie;

endmodule

// ==== hw/io_gpio.sv ====
// GPIO slave on the IO bus.
// Holds the output pins, synchronizes the input pins and records
// rising edges until software clears them by writing ones.

`timescale 1ns/10ps

`include "io_params.svh"

module io_gpio
	import io_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	// IO bus
	input  logic                      io_we,
	input  logic                      io_radr_en,
	input  io_adr_t                   io_adr,
	input  io_data_t                  io_wdata,
	input  io_data_t                  io_rdata_in,
	output io_data_t                  io_rdata,
	// Pins
	input  logic [`IO_GPIO_WIDTH-1:0] gpio_in,
	output logic [`IO_GPIO_WIDTH-1:0] gpio_out
);

	logic [`IO_GPIO_WIDTH-1:0] in_meta;
	logic [`IO_GPIO_WIDTH-1:0] in_sync;
	logic [`IO_GPIO_WIDTH-1:0] in_prev;
	logic [`IO_GPIO_WIDTH-1:0] edge_q;
	logic [`IO_GPIO_WIDTH-1:0] rise;
	logic [`IO_GPIO_WIDTH-1:0] edge_clr;

	// Rising edge of the synchronized input
	assign rise     = in_sync & ~in_prev;
	assign edge_clr = (io_we && (io_adr == `IO_GPIO_EDGE)) ?
		io_wdata[`IO_GPIO_WIDTH-1:0] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gpio_out <= '0;
			in_meta  <= '0;
			in_sync  <= '0;
			in_prev  <= '0;
			edge_q   <= '0;
		end else begin
			if (io_we && (io_adr == `IO_GPIO_OUT))
				gpio_out <= io_wdata[`IO_GPIO_WIDTH-1:0];
			in_meta <= gpio_in;
			in_sync <= in_meta;
			in_prev <= in_sync;
			// A new edge beats a clear in the same cycle
			edge_q <= (edge_q & ~edge_clr) | rise;
		end
	end

	always_comb begin
		io_rdata = io_rdata_in;
		if (io_radr_en) begin
			case (io_adr)
				`IO_GPIO_OUT:  io_rdata = 32'(gpio_out);
				`IO_GPIO_IN:   io_rdata = 32'(in_sync);
				`IO_GPIO_EDGE: io_rdata = 32'(edge_q);
				default:       io_rdata = io_rdata_in;
			endcase
		end
	end

endmodule

// ==== hw/io_pkg.sv ====
// Types shared by the IO subsystem RTL and its testbench.
// Modules import the package in their header.

package io_pkg;

	// Word address on the IO bus, byte address bits 15 down to 2
	typedef logic [13:0] io_adr_t;

	// Data word on AXI4-Lite and on the IO bus
	typedef logic [31:0] io_data_t;

	// AXI4-Lite response code
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t AXIL_OKAY = 2'b00;

	// Master index seen by the arbiter
	typedef logic io_mst_t;

	localparam io_mst_t MST_CPU = 1'b0;
	localparam io_mst_t MST_DMA = 1'b1;

endpackage

// ==== hw/io_subsys_top.sv ====
// IO subsystem top level.
// CPU and DMA AXI4-Lite ports share one IO bus through a round-robin
// arbiter; the bus serves the GPIO block and the free-run counter.

`timescale 1ns/10ps

module io_subsys_top
	import io_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	// CPU data port
	input  logic        cpu_awvalid,
	output logic        cpu_awready,
	input  logic [31:0] cpu_awaddr,
	input  logic        cpu_wvalid,
	output logic        cpu_wready,
	input  io_data_t    cpu_wdata,
	output logic        cpu_bvalid,
	input  logic        cpu_bready,
	output axil_resp_t  cpu_bresp,
	input  logic        cpu_arvalid,
	output logic        cpu_arready,
	input  logic [31:0] cpu_araddr,
	output logic        cpu_rvalid,
	input  logic        cpu_rready,
	output io_data_t    cpu_rdata,
	output axil_resp_t  cpu_rresp,
	// DMA port
	input  logic        dma_awvalid,
	output logic        dma_awready,
	input  logic [31:0] dma_awaddr,
	input  logic        dma_wvalid,
	output logic        dma_wready,
	input  io_data_t    dma_wdata,
	output logic        dma_bvalid,
	input  logic        dma_bready,
	output axil_resp_t  dma_bresp,
	input  logic        dma_arvalid,
	output logic        dma_arready,
	input  logic [31:0] dma_araddr,
	output logic        dma_rvalid,
	input  logic        dma_rready,
	output io_data_t    dma_rdata,
	output axil_resp_t  dma_rresp,
	// Core and pins
	input  logic        csr_mtie,
	output logic        frc_cntr_val_leq,
	input  logic [7:0]  gpio_in,
	output logic [7:0]  gpio_out
);

	logic     cpu_req, cpu_req_we, cpu_gnt;
	io_adr_t  cpu_req_adr;
	io_data_t cpu_req_wdata;
	logic     dma_req, dma_req_we, dma_gnt;
	io_adr_t  dma_req_adr;
	io_data_t dma_req_wdata;
	io_data_t gnt_rdata;

	logic     io_we, io_radr_en;
	io_adr_t  io_adr;
	io_data_t io_wdata;
	io_data_t gpio_rdata;
	io_data_t frc_rdata;

	axil_io_bridge u_cpu_bridge (
		.clk, .rst_n,
		.awvalid(cpu_awvalid), .awready(cpu_awready), .awaddr(cpu_awaddr),
		.wvalid(cpu_wvalid), .wready(cpu_wready), .wdata(cpu_wdata),
		.bvalid(cpu_bvalid), .bready(cpu_bready), .bresp(cpu_bresp),
		.arvalid(cpu_arvalid), .arready(cpu_arready), .araddr(cpu_araddr),
		.rvalid(cpu_rvalid), .rready(cpu_rready), .rdata(cpu_rdata), .rresp(cpu_rresp),
		.req(cpu_req), .req_we(cpu_req_we), .req_adr(cpu_req_adr),
		.req_wdata(cpu_req_wdata), .gnt(cpu_gnt), .gnt_rdata(gnt_rdata)
	);

	axil_io_bridge u_dma_bridge (
		.clk, .rst_n,
		.awvalid(dma_awvalid), .awready(dma_awready), .awaddr(dma_awaddr),
		.wvalid(dma_wvalid), .wready(dma_wready), .wdata(dma_wdata),
		.bvalid(dma_bvalid), .bready(dma_bready), .bresp(dma_bresp),
		.arvalid(dma_arvalid), .arready(dma_arready), .araddr(dma_araddr),
		.rvalid(dma_rvalid), .rready(dma_rready), .rdata(dma_rdata), .rresp(dma_rresp),
		.req(dma_req), .req_we(dma_req_we), .req_adr(dma_req_adr),
		.req_wdata(dma_req_wdata), .gnt(dma_gnt), .gnt_rdata(gnt_rdata)
	);

	io_bus_arbiter u_arbiter (
		.clk, .rst_n,
		.cpu_req, .cpu_we(cpu_req_we), .cpu_adr(cpu_req_adr),
		.cpu_wdata(cpu_req_wdata), .cpu_gnt,
		.dma_req, .dma_we(dma_req_we), .dma_adr(dma_req_adr),
		.dma_wdata(dma_req_wdata), .dma_gnt,
		.gnt_rdata,
		.io_we, .io_radr_en, .io_adr, .io_wdata, .io_rdata(frc_rdata)
	);

	// Read chain starts at zero, GPIO first, counter last
	io_gpio u_gpio (
		.clk, .rst_n,
		.io_we, .io_radr_en, .io_adr, .io_wdata,
		.io_rdata_in(32'd0), .io_rdata(gpio_rdata),
		.gpio_in, .gpio_out
	);

	io_frc u_frc (
		.clk, .rst_n,
		.io_we, .io_radr_en, .io_adr, .io_wdata,
		.io_rdata_in(gpio_rdata), .io_rdata(frc_rdata),
		.csr_mtie, .frc_cntr_val_leq
	);

endmodule

// ==== include/io_params.svh ====
// IO register map and sizes of the IO subsystem.
// Include where IO register addresses or peripheral widths are needed.
// Addresses are word addresses, that is byte address bits 15 down to 2.

`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Free-run counter registers
`define IO_FRC_VALLO 14'h3E00
`define IO_FRC_VALHI 14'h3E01
`define IO_FRC_CMPLO 14'h3E02
`define IO_FRC_CMPHI 14'h3E03
`define IO_FRC_CNTRL 14'h3E04

// GPIO registers
`define IO_GPIO_OUT  14'h3F00
`define IO_GPIO_IN   14'h3F01
`define IO_GPIO_EDGE 14'h3F02

// Counter and compare register width
// High words carry the bits above 31
`define IO_FRC_WIDTH 40

// Number of GPIO pins in each direction
`define IO_GPIO_WIDTH 8

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the IO subsystem testbench with Verilator and runs it.
# Exits with a failing status when the simulation reports a failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_io_subsys -o sim_io_subsys

status=0
./obj_dir/sim_io_subsys > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// ==== sources.f ====
+incdir+include
hw/io_pkg.sv
hw/axil_io_bridge.sv
hw/io_bus_arbiter.sv
hw/io_gpio.sv
hw/io_frc.sv
hw/io_subsys_top.sv
bench/tb_io_subsys.sv
